// ==== verilog.f ====
source/exe_pkg.sv
source/exe_alu.sv
source/exe_divider.sv
source/exe_lsu.sv
source/exe_branch.sv
source/exe_stage.sv
tb/exe_checker.sv
tb/exe_stage_tb.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing
TOP      = exe_stage_tb
FILELIST = verilog.f
LOG      = sim.log

.PHONY: sim clean

# build, run, then decide on the log
sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -qF '>>> PASS' $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== tb/exe_cases.txt ====
# op     src1     src2     imm      pc       pj | result   nj target   pf ale
# all values hex, pj nj pf ale single bits, memory address is src1 + imm
add      7fffffff 00000001 00000000 00000000 0  80000000 0 00000000 0 0
sub      00000005 00000007 00000000 00000000 0  fffffffe 0 00000000 0 0
slt      ffffffff 00000001 00000000 00000000 0  00000001 0 00000000 0 0
sltu     ffffffff 00000001 00000000 00000000 0  00000000 0 00000000 0 0
slt      00000001 80000000 00000000 00000000 0  00000000 0 00000000 0 0
sltu     00000001 80000000 00000000 00000000 0  00000001 0 00000000 0 0
and      f0f0f0f0 ff00ff00 00000000 00000000 0  f000f000 0 00000000 0 0
nor      f0f0f0f0 0f0f0000 00000000 00000000 0  00000f0f 0 00000000 0 0
or       12340000 00005678 00000000 00000000 0  12345678 0 00000000 0 0
xor      ffff0000 0ff00ff0 00000000 00000000 0  f00f0ff0 0 00000000 0 0
sll      00000001 0000001f 00000000 00000000 0  80000000 0 00000000 0 0
sll      00000003 00000024 00000000 00000000 0  00000030 0 00000000 0 0
srl      80000000 0000003f 00000000 00000000 0  00000001 0 00000000 0 0
sra      80000010 00000004 00000000 00000000 0  f8000001 0 00000000 0 0
sra      ffffff00 0000001f 00000000 00000000 0  ffffffff 0 00000000 0 0
lui      00000000 12345000 00000000 00000000 0  12345000 0 00000000 0 0
div      fffffff9 00000002 00000000 00000000 0  fffffffd 0 00000000 0 0
mod      fffffff9 00000002 00000000 00000000 0  ffffffff 0 00000000 0 0
divu     fffffff9 00000002 00000000 00000000 0  7ffffffc 0 00000000 0 0
modu     fffffff9 00000002 00000000 00000000 0  00000001 0 00000000 0 0
div      00000064 fffffff9 00000000 00000000 0  fffffff2 0 00000000 0 0
mod      00000064 fffffff9 00000000 00000000 0  00000002 0 00000000 0 0
divu     ffffffff 00000010 00000000 00000000 0  0fffffff 0 00000000 0 0
modu     ffffffff 00000010 00000000 00000000 0  0000000f 0 00000000 0 0
div      00001234 00000000 00000000 00000000 0  ffffffff 0 00000000 0 0
mod      00001234 00000000 00000000 00000000 0  00001234 0 00000000 0 0
divu     00001234 00000000 00000000 00000000 0  ffffffff 0 00000000 0 0
modu     80000000 00000000 00000000 00000000 0  80000000 0 00000000 0 0
div      80000000 ffffffff 00000000 00000000 0  80000000 0 00000000 0 0
mod      80000000 ffffffff 00000000 00000000 0  00000000 0 00000000 0 0
st_w     00000100 11223344 00000000 00000000 0  00000000 0 00000000 0 0
st_b     00000100 000000a5 00000005 00000000 0  00000000 0 00000000 0 0
st_h     00000100 1234beef 0000000a 00000000 0  00000000 0 00000000 0 0
st_b     00000100 12345680 00000007 00000000 0  00000000 0 00000000 0 0
ld_w     00000100 00000000 00000000 00000000 0  11223344 0 00000000 0 0
ld_b     00000100 00000000 00000005 00000000 0  ffffffa5 0 00000000 0 0
ld_bu    00000100 00000000 00000005 00000000 0  000000a5 0 00000000 0 0
ld_h     00000100 00000000 0000000a 00000000 0  ffffbeef 0 00000000 0 0
ld_hu    00000100 00000000 0000000a 00000000 0  0000beef 0 00000000 0 0
ld_b     00000100 00000000 00000007 00000000 0  ffffff80 0 00000000 0 0
ld_h     00000100 00000000 00000006 00000000 0  ffff8000 0 00000000 0 0
ld_hu    00000100 00000000 00000004 00000000 0  0000a500 0 00000000 0 0
ld_b     00000100 00000000 00000002 00000000 0  00000022 0 00000000 0 0
ld_bu    00000100 00000000 00000003 00000000 0  00000011 0 00000000 0 0
ld_w     00000100 00000000 00000008 00000000 0  beef0000 0 00000000 0 0
ld_w     00000100 00000000 00000002 00000000 0  00000000 0 00000000 0 1
ld_h     00000100 00000000 00000005 00000000 0  00000000 0 00000000 0 1
st_w     00000100 ffffffff 00000001 00000000 0  00000000 0 00000000 0 1
st_h     00000100 ffffffff 00000003 00000000 0  00000000 0 00000000 0 1
ld_w     00000100 00000000 00000004 00000000 0  8000a500 0 00000000 0 0
ld_w     00000100 00000000 00000000 00000000 0  11223344 0 00000000 0 0
beq      00000005 00000005 00000010 00001000 0  00001004 1 00001040 1 0
beq      00000005 00000006 00000010 00001000 1  00001004 0 00001004 1 0
bne      00000005 00000006 00000010 00001000 1  00001004 1 00001040 0 0
bne      00000005 00000005 00000010 00001000 0  00001004 0 00001040 0 0
blt      ffffffff 00000001 fffffffc 00001000 1  00001004 1 00000ff0 0 0
blt      00000001 ffffffff fffffffc 00001000 0  00001004 0 00000ff0 0 0
bge      ffffffff 00000001 00000010 00001000 1  00001004 0 00001004 1 0
bge      00000001 ffffffff 00000010 00001000 0  00001004 1 00001040 1 0
bltu     ffffffff 00000001 00000010 00001000 0  00001004 0 00001040 0 0
bltu     00000001 ffffffff 00000010 00001000 1  00001004 1 00001040 0 0
bgeu     ffffffff 00000001 00000010 00001000 1  00001004 1 00001040 0 0
bgeu     00000001 ffffffff 00000010 00001000 0  00001004 0 00001040 0 0
jirl     00002000 00000000 00000003 00001000 1  00001004 1 0000200c 0 0
jirl     00002000 00000000 00000003 00001000 0  00001004 1 0000200c 1 0
b        00000000 00000000 00000100 00001000 0  00001004 1 00001400 1 0
b        00000000 00000000 00000100 00001000 1  00001004 1 00001400 0 0

// ==== tb/exe_stage_tb.sv ====
`timescale 1ns/1ns
module exe_stage_tb;
  import exe_pkg::*;

  // cycles any single wait may take
  localparam int wait_limit = 200;

  logic        clk;
  logic        rst_n;
  logic        req_valid;
  logic        req_ready;
  exe_req_t    req;
  logic        rsp_valid;
  logic        rsp_ready;
  exe_rsp_t    rsp;
  logic        dc_req_valid;
  logic        dc_req_ready;
  dcache_req_t dc_req;
  logic        dc_rvalid;
  word_t       dc_rdata;
  int          mismatches;
  int          checked;
  int          issued;
  int          bad_lines;
  int          timeouts;
  integer      seed;
  // data memory behind the cache port, word indexed
  word_t       mem [256] = '{default: '0};

  exe_stage u_dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .req_valid    (req_valid),
    .req_ready    (req_ready),
    .req          (req),
    .rsp_valid    (rsp_valid),
    .rsp_ready    (rsp_ready),
    .rsp          (rsp),
    .dc_req_valid (dc_req_valid),
    .dc_req_ready (dc_req_ready),
    .dc_req       (dc_req),
    .dc_rvalid    (dc_rvalid),
    .dc_rdata     (dc_rdata)
  );

  exe_checker u_check (
    .clk       (clk),
    .rst_n     (rst_n),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready),
    .rsp       (rsp),
    .errors    (mismatches),
    .checked   (checked)
  );

  // 20 ns clock
  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // look up an op by its mnemonic, enum names carry an op_ prefix
  function automatic void find_op(input string name, output exe_op_t op, output logic known);
    exe_op_t o;
    int      i;
    o     = o.first();
    op    = o;
    known = 1'b0;
    for (i = 0; i < o.num(); i++) begin
      if (o.name() == {"op_", name}) begin
        op    = o;
        known = 1'b1;
      end
      o = o.next();
    end
  endfunction

  // present one request and hold it until accepted
  task automatic issue(input exe_req_t r, output logic ok);
    int waited;
    waited    = 0;
    req       = r;
    req_valid = 1'b1;
    @(negedge clk);
    while (!req_ready && waited < wait_limit) begin
      waited++;
      @(negedge clk);
    end
    ok = req_ready;
    @(posedge clk);
    #2;
    req_valid = 1'b0;
  endtask

  // cache port model, random stalls and read latency, random result back-pressure
  initial begin
    logic        hs;
    dcache_req_t hs_req;
    word_t       mask;
    logic        pending;
    int          countdown;
    logic [7:0]  ridx;
    seed         = 60421;
    pending      = 1'b0;
    countdown    = 0;
    ridx         = '0;
    dc_req_ready = 1'b0;
    dc_rvalid    = 1'b0;
    dc_rdata     = '0;
    rsp_ready    = 1'b0;
    forever begin
      // handshake is decided by the values before the edge
      @(negedge clk);
      hs     = dc_req_valid && dc_req_ready;
      hs_req = dc_req;
      @(posedge clk);
      #2;
      dc_rvalid = 1'b0;
      if (hs && hs_req.we) begin
        mask = {{8{hs_req.wstrb[3]}}, {8{hs_req.wstrb[2]}},
                {8{hs_req.wstrb[1]}}, {8{hs_req.wstrb[0]}}};
        mem[hs_req.addr[9:2]] = (mem[hs_req.addr[9:2]] & ~mask) | (hs_req.wdata & mask);
      end else if (hs) begin
        pending   = 1'b1;
        ridx      = hs_req.addr[9:2];
        countdown = $random(seed) & 3;
      end
      // read data 1 to 4 cycles after the request
      if (pending) begin
        if (countdown == 0) begin
          dc_rvalid = 1'b1;
          dc_rdata  = mem[ridx];
          pending   = 1'b0;
        end else begin
          countdown--;
        end
      end
      dc_req_ready = (($random(seed) & 3) != 0);
      rsp_ready    = (($random(seed) & 3) != 0);
    end
  end

  // stimulus from the cases file, one instruction per line
  initial begin
    int      fd;
    int      n;
    int      waited;
    string   line;
    string   op_name;
    exe_op_t op;
    logic    known;
    logic    ok;
    exe_req_t r;
    word_t   src1;
    word_t   src2;
    word_t   imm;
    word_t   pc;
    logic    pj;
    word_t   skip_w;
    logic    skip_b;
    issued    = 0;
    bad_lines = 0;
    timeouts  = 0;
    rst_n     = 1'b0;
    req_valid = 1'b0;
    req       = '0;
    repeat (8) @(posedge clk);
    #2;
    rst_n = 1'b1;
    fd = $fopen("tb/exe_cases.txt", "r");
    if (fd == 0) begin
      $display("cannot open tb/exe_cases.txt");
      bad_lines++;
    end
    while (fd != 0 && timeouts == 0 && !$feof(fd)) begin
      n = $fgets(line, fd);
      n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h", op_name, src1, src2, imm, pc,
                  pj, skip_w, skip_b, skip_w, skip_b, skip_b);
      if (n == 11 && op_name.getc(0) != "#") begin
        find_op(op_name, op, known);
        if (!known) begin
          $display("unknown op %s in the cases file", op_name);
          bad_lines++;
        end else begin
          r          = '0;
          r.op       = op;
          r.src1     = src1;
          r.src2     = src2;
          r.imm      = imm;
          r.pc       = pc;
          r.pre_jump = pj;
          issue(r, ok);
          if (ok) begin
            issued++;
          end else begin
            $display("timeout: issue handshake stalled, req_ready low for %0d cycles",
                     wait_limit);
            timeouts++;
          end
        end
      end else if (n > 0 && op_name.getc(0) != "#") begin
        $display("badly formed line in the cases file: %s", line);
        bad_lines++;
      end
    end
    // drain the last results
    waited = 0;
    while (checked < issued && waited < wait_limit) begin
      @(posedge clk);
      waited++;
    end
    if (checked < issued) begin
      $display("timeout: result handshake stalled, %0d of %0d results taken", checked, issued);
      timeouts++;
    end
    $display("closing: %0d checker errors, %0d bad case lines, %0d timeouts, %0d of %0d checked",
             mismatches, bad_lines, timeouts, checked, issued);
    if (mismatches == 0 && bad_lines == 0 && timeouts == 0 && issued > 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// ==== tb/exe_checker.sv ====
`timescale 1ns/1ns
module exe_checker (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              rsp_valid,
  input  logic              rsp_ready,
  input  exe_pkg::exe_rsp_t rsp,
  output int                errors,
  output int                checked
);
  import exe_pkg::*;

  int       fd;
  int       err_count = 0;
  int       rsp_count = 0;
  logic     stall_seen = 1'b0;
  exe_rsp_t held_rsp;
  string    exp_op;
  word_t    e_result;
  logic     e_need_jump;
  word_t    e_target;
  logic     e_pre_fail;
  logic     e_ale;

  assign errors  = err_count;
  assign checked = rsp_count;

  // same cases file as the driver, expected columns only
  initial begin
    fd = $fopen("tb/exe_cases.txt", "r");
  end

  // next line with all eleven columns, comment lines skipped
  task automatic next_case(output logic found);
    string line;
    int    n;
    word_t skip_w;
    logic  skip_b;
    found = 1'b0;
    while (!found && fd != 0 && !$feof(fd)) begin
      n = $fgets(line, fd);
      n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h", exp_op, skip_w, skip_w,
                  skip_w, skip_w, skip_b, e_result, e_need_jump, e_target, e_pre_fail, e_ale);
      found = (n == 11) && (exp_op.getc(0) != "#");
    end
  endtask

  // one field against its expected value
  task automatic check_field(input string field, input word_t got, input word_t exp);
    if (got !== exp) begin
      err_count++;
      $display("Mismatch at %0t: result %0d (%s) %s is %h, expected %h",
               $time, rsp_count, exp_op, field, got, exp);
    end
  endtask

  // sampled mid-cycle, handshake completes on the next rising edge
  always @(negedge clk) begin
    logic found;
    if (rst_n) begin
      // held output must not move while stalled
      if (stall_seen && rsp !== held_rsp) begin
        err_count++;
        $display("Mismatch at %0t: result port changed while held by back-pressure", $time);
      end
      if (rsp_valid && rsp_ready) begin
        next_case(found);
        if (!found) begin
          err_count++;
          $display("result %0d arrived at %0t with no expected line left in the cases file",
                   rsp_count, $time);
        end else begin
          check_field("result", rsp.result, e_result);
          check_field("need_jump", word_t'(rsp.need_jump), word_t'(e_need_jump));
          check_field("jump_target", rsp.jump_target, e_target);
          check_field("pre_fail", word_t'(rsp.pre_fail), word_t'(e_pre_fail));
          check_field("excp_ale", word_t'(rsp.excp_ale), word_t'(e_ale));
        end
        rsp_count++;
      end
      stall_seen = rsp_valid && !rsp_ready;
      held_rsp   = rsp;
    end
  end

endmodule

// ==== source/exe_stage.sv ====
`timescale 1ns/1ns
module exe_stage (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 req_valid,
  output logic                 req_ready,
  input  exe_pkg::exe_req_t    req,
  output logic                 rsp_valid,
  input  logic                 rsp_ready,
  output exe_pkg::exe_rsp_t    rsp,
  output logic                 dc_req_valid,
  input  logic                 dc_req_ready,
  output exe_pkg::dcache_req_t dc_req,
  input  logic                 dc_rvalid,
  input  exe_pkg::word_t       dc_rdata
);
  import exe_pkg::*;

  exe_req_t req_q;
  logic     busy;
  logic     launch;
  logic     is_div;
  logic     is_mem;
  logic     is_br;
  logic     unit_done;
  word_t    alu_result;
  logic     alu_less;
  logic     alu_zero;
  logic     div_done;
  word_t    div_result;
  logic     lsu_done;
  word_t    lsu_result;
  logic     lsu_excp;
  logic     br_need_jump;
  addr_t    br_target;
  logic     br_pre_fail;
  addr_t    mem_addr;
  exe_rsp_t rsp_next;

  // one instruction in flight, no issue while a result waits
  assign req_ready = !busy && !rsp_valid;

  // unit select from the held op, alu otherwise
  assign is_div = req_q.op inside {op_div, op_divu, op_mod, op_modu};
  assign is_mem = req_q.op inside {op_ld_b, op_ld_bu, op_ld_h, op_ld_hu, op_ld_w,
                                   op_st_b, op_st_h, op_st_w};
  assign is_br  = req_q.op inside {op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu,
                                   op_jirl, op_b};

  // alu and branch finish in the launch cycle
  assign unit_done = is_div ? div_done : (is_mem ? lsu_done : launch);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy      <= 1'b0;
      launch    <= 1'b0;
      rsp_valid <= 1'b0;
    end else begin
      launch <= req_valid && req_ready;
      if (req_valid && req_ready) begin
        busy <= 1'b1;
      end else if (busy && unit_done) begin
        busy <= 1'b0;
      end
      if (busy && unit_done) begin
        rsp_valid <= 1'b1;
      end else if (rsp_ready) begin
        rsp_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (req_valid && req_ready) begin
      req_q <= req;
    end
    // held until taken
    if (busy && unit_done) begin
      rsp <= rsp_next;
    end
  end

  assign mem_addr = req_q.src1 + req_q.imm;

  exe_alu u_alu (
    .op     (req_q.op),
    .src1   (req_q.src1),
    .src2   (req_q.src2),
    .result (alu_result),
    .less   (alu_less),
    .zero   (alu_zero)
  );

  exe_divider u_div (
    .clk         (clk),
    .rst_n       (rst_n),
    .start       (launch && is_div),
    .is_unsigned (req_q.op inside {op_divu, op_modu}),
    .use_mod     (req_q.op inside {op_mod, op_modu}),
    .dividend    (req_q.src1),
    .divisor     (req_q.src2),
    .done        (div_done),
    .result      (div_result)
  );

  exe_lsu u_lsu (
    .clk          (clk),
    .rst_n        (rst_n),
    .start        (launch && is_mem),
    .op           (req_q.op),
    .addr         (mem_addr),
    .wdata        (req_q.src2),
    .done         (lsu_done),
    .result       (lsu_result),
    .excp_ale     (lsu_excp),
    .dc_req_valid (dc_req_valid),
    .dc_req_ready (dc_req_ready),
    .dc_req       (dc_req),
    .dc_rvalid    (dc_rvalid),
    .dc_rdata     (dc_rdata)
  );

  exe_branch u_br (
    .op          (req_q.op),
    .less        (alu_less),
    .zero        (alu_zero),
    .pc          (req_q.pc),
    .rj          (req_q.src1),
    .imm         (req_q.imm),
    .pre_jump    (req_q.pre_jump),
    .need_jump   (br_need_jump),
    .jump_target (br_target),
    .pre_fail    (br_pre_fail)
  );

  // branches write back the link address
  always_comb begin
    if (is_div) begin
      rsp_next.result = div_result;
    end else if (is_mem) begin
      rsp_next.result = lsu_result;
    end else if (is_br) begin
      rsp_next.result = req_q.pc + addr_t'(4);
    end else begin
      rsp_next.result = alu_result;
    end
    rsp_next.need_jump   = is_br && br_need_jump;
    rsp_next.jump_target = is_br ? br_target : '0;
    rsp_next.pre_fail    = is_br && br_pre_fail;
    rsp_next.excp_ale    = is_mem && lsu_excp;
  end

endmodule

// ==== source/exe_branch.sv ====
`timescale 1ns/1ns
module exe_branch (
  input  exe_pkg::exe_op_t op,
  input  logic             less,
  input  logic             zero,
  input  exe_pkg::addr_t   pc,
  input  exe_pkg::word_t   rj,
  input  exe_pkg::word_t   imm,
  input  logic             pre_jump,
  output logic             need_jump,
  output exe_pkg::addr_t   jump_target,
  output logic             pre_fail
);
  import exe_pkg::*;

  addr_t base;
  addr_t offset;

  // taken condition from the alu compare flags
  always_comb begin
    case (op)
      op_beq:           need_jump = zero;
      op_bne:           need_jump = !zero;
      op_blt, op_bltu:  need_jump = less;
      op_bge, op_bgeu:  need_jump = !less;
      op_jirl, op_b:    need_jump = 1'b1;
      default:          need_jump = 1'b0;
    endcase
  end

  // jirl is register relative, the rest pc relative
  assign base   = (op == op_jirl) ? rj : pc;
  assign offset = {imm[word_w-3:0], 2'b00};

  // predicted taken but falls through, so redirect to the next pc
  assign jump_target = (!need_jump && pre_jump) ? pc + addr_t'(4) : base + offset;
  assign pre_fail    = need_jump ^ pre_jump;

endmodule

// ==== source/exe_lsu.sv ====
`timescale 1ns/1ns
module exe_lsu (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 start,
  input  exe_pkg::exe_op_t     op,
  input  exe_pkg::addr_t       addr,
  input  exe_pkg::word_t       wdata,
  output logic                 done,
  output exe_pkg::word_t       result,
  output logic                 excp_ale,
  output logic                 dc_req_valid,
  input  logic                 dc_req_ready,
  output exe_pkg::dcache_req_t dc_req,
  input  logic                 dc_rvalid,
  input  exe_pkg::word_t       dc_rdata
);
  import exe_pkg::*;

  // access size encoding
  localparam logic [1:0] sz_byte = 2'd0;
  localparam logic [1:0] sz_half = 2'd1;
  localparam logic [1:0] sz_word = 2'd2;

  lsu_state_t state;
  logic       is_store;
  logic       is_signed;
  logic [1:0] size;
  logic [1:0] offset;
  logic       misaligned;
  shamt_t     bit_off;
  strb_t      strb;
  word_t      rdata_sh;
  word_t      load_data;

  // decode size and extension from op
  always_comb begin
    is_store  = 1'b0;
    is_signed = 1'b0;
    size      = sz_word;
    case (op)
      op_ld_b:  begin size = sz_byte; is_signed = 1'b1; end
      op_ld_bu: size = sz_byte;
      op_ld_h:  begin size = sz_half; is_signed = 1'b1; end
      op_ld_hu: size = sz_half;
      op_st_b:  begin size = sz_byte; is_store = 1'b1; end
      op_st_h:  begin size = sz_half; is_store = 1'b1; end
      op_st_w:  is_store = 1'b1;
      default:  size = sz_word;
    endcase
  end

  assign offset     = addr[1:0];
  assign bit_off    = {offset, 3'b000};
  assign misaligned = ((size == sz_word) && (offset != 2'b00))
                    || ((size == sz_half) && offset[0]);

  // strobes cover the bytes of the access
  always_comb begin
    case (size)
      sz_byte: strb = strb_t'(4'b0001) << offset;
      sz_half: strb = strb_t'(4'b0011) << offset;
      default: strb = '1;
    endcase
  end

  // byte lane 0 of the shifted data is the addressed byte
  assign rdata_sh = dc_rdata >> bit_off;
  always_comb begin
    case (size)
      sz_byte: load_data = {{(word_w-8){is_signed & rdata_sh[7]}}, rdata_sh[7:0]};
      sz_half: load_data = {{(word_w-16){is_signed & rdata_sh[15]}}, rdata_sh[15:0]};
      default: load_data = rdata_sh;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= lsu_idle;
    end else begin
      case (state)
        lsu_idle: begin
          if (start) begin
            state <= misaligned ? lsu_fault : lsu_request;
          end
        end
        lsu_request: begin
          // stores finish on the handshake, loads wait for data
          if (dc_req_ready) begin
            state <= is_store ? lsu_idle : lsu_wait_data;
          end
        end
        lsu_wait_data: begin
          if (dc_rvalid) begin
            state <= lsu_idle;
          end
        end
        default: state <= lsu_idle;
      endcase
    end
  end

  assign dc_req_valid = (state == lsu_request);
  assign dc_req.addr  = {addr[word_w-1:2], 2'b00};
  assign dc_req.we    = is_store;
  assign dc_req.wstrb = is_store ? strb : '0;
  assign dc_req.wdata = wdata << bit_off;

  assign done = (state == lsu_fault)
              || ((state == lsu_request) && dc_req_ready && is_store)
              || ((state == lsu_wait_data) && dc_rvalid);
  // stores and faults return zero
  assign result   = (state == lsu_wait_data) ? load_data : '0;
  assign excp_ale = (state == lsu_fault);

endmodule

// ==== source/exe_divider.sv ====
`timescale 1ns/1ns
module exe_divider (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           start,
  input  logic           is_unsigned,
  input  logic           use_mod,
  input  exe_pkg::word_t dividend,
  input  exe_pkg::word_t divisor,
  output logic           done,
  output exe_pkg::word_t result
);
  import exe_pkg::*;

  localparam int unsigned iter_w = $clog2(word_w);

  div_state_t        state;
  logic [iter_w-1:0] iter;
  word_t             quo;
  word_t             rem;
  word_t             dvs;
  word_t             dvd_orig;
  logic              neg_q;
  logic              neg_r;
  logic              mod_q;
  logic              div_zero;
  word_t             dvd_mag;
  word_t             dvs_mag;
  logic [word_w:0]   rem_shift;
  logic [word_w:0]   diff;

  // operand magnitudes for the unsigned core
  assign dvd_mag = (!is_unsigned && dividend[word_w-1]) ? -dividend : dividend;
  assign dvs_mag = (!is_unsigned && divisor[word_w-1]) ? -divisor : divisor;

  // next dividend bit into the partial remainder, then trial subtract
  assign rem_shift = {rem, quo[word_w-1]};
  assign diff      = rem_shift - {1'b0, dvs};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= div_idle;
      iter  <= '0;
    end else begin
      case (state)
        div_idle: begin
          if (start) begin
            state <= div_run;
            iter  <= '0;
          end
        end
        div_run: begin
          iter <= iter + 1'b1;
          // one quotient bit per cycle
          if (iter == iter_w'(word_w - 1)) begin
            state <= div_finish;
          end
        end
        default: state <= div_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == div_idle && start) begin
      quo      <= dvd_mag;
      rem      <= '0;
      dvs      <= dvs_mag;
      dvd_orig <= dividend;
      neg_q    <= !is_unsigned && (dividend[word_w-1] ^ divisor[word_w-1]);
      // remainder follows the dividend sign
      neg_r    <= !is_unsigned && dividend[word_w-1];
      mod_q    <= use_mod;
      div_zero <= (divisor == '0);
    end else if (state == div_run) begin
      if (!diff[word_w]) begin
        rem <= diff[word_w-1:0];
        quo <= {quo[word_w-2:0], 1'b1};
      end else begin
        // restore
        rem <= rem_shift[word_w-1:0];
        quo <= {quo[word_w-2:0], 1'b0};
      end
    end
  end

  assign done = (state == div_finish);

  // sign fix-up, x/0 gives all ones and x%0 gives x
  always_comb begin
    if (div_zero) begin
      result = mod_q ? dvd_orig : '1;
    end else if (mod_q) begin
      result = neg_r ? -rem : rem;
    end else begin
      result = neg_q ? -quo : quo;
    end
  end

endmodule

// ==== source/exe_alu.sv ====
`timescale 1ns/1ns
module exe_alu (
  input  exe_pkg::exe_op_t op,
  input  exe_pkg::word_t   src1,
  input  exe_pkg::word_t   src2,
  output exe_pkg::word_t   result,
  output logic             less,
  output logic             zero
);
  import exe_pkg::*;

  exe_op_t             alu_op;
  logic                do_sub;
  word_t               adder_b;
  word_t               adder_sum;
  logic                adder_cout;
  logic                slt_bit;
  logic                sltu_bit;
  shamt_t              sa;
  logic [2*word_w-1:0] sr_wide;

  // branch compares reuse sub, slt and sltu
  always_comb begin
    case (op)
      op_beq, op_bne:   alu_op = op_sub;
      op_blt, op_bge:   alu_op = op_slt;
      op_bltu, op_bgeu: alu_op = op_sltu;
      default:          alu_op = op;
    endcase
  end

  // one shared adder, src1 - src2 as src1 + ~src2 + 1
  assign do_sub  = alu_op inside {op_sub, op_slt, op_sltu};
  assign adder_b = do_sub ? ~src2 : src2;
  assign {adder_cout, adder_sum} = {1'b0, src1} + {1'b0, adder_b} + {{word_w{1'b0}}, do_sub};

  // signed less: signs differ, or same sign and negative difference
  assign slt_bit = (src1[word_w-1] & ~src2[word_w-1])
                 | (~(src1[word_w-1] ^ src2[word_w-1]) & adder_sum[word_w-1]);
  // unsigned less: borrow out
  assign sltu_bit = ~adder_cout;

  assign sa = src2[$bits(shamt_t)-1:0];
  // srl and sra share one wide shifter, upper half is the fill
  assign sr_wide = {{word_w{(alu_op == op_sra) & src1[word_w-1]}}, src1} >> sa;

  always_comb begin
    case (alu_op)
      op_add, op_sub: result = adder_sum;
      op_slt:         result = {{(word_w-1){1'b0}}, slt_bit};
      op_sltu:        result = {{(word_w-1){1'b0}}, sltu_bit};
      op_and:         result = src1 & src2;
      op_nor:         result = ~(src1 | src2);
      op_or:          result = src1 | src2;
      op_xor:         result = src1 ^ src2;
      op_sll:         result = src1 << sa;
      op_srl, op_sra: result = sr_wide[word_w-1:0];
      // immediate already placed in the upper bits
      op_lui:         result = src2;
      default:        result = '0;
    endcase
  end

  // flags for the branch unit
  assign less = result[0];
  assign zero = ~|result;

endmodule

// ==== source/exe_pkg.sv ====
package exe_pkg;

  // datapath width, fixed by the isa
  localparam int unsigned word_w = 32;

  typedef logic [word_w-1:0]         word_t;
  typedef logic [word_w-1:0]         addr_t;
  typedef logic [word_w/8-1:0]       strb_t;
  typedef logic [$clog2(word_w)-1:0] shamt_t;

  // every op the stage understands
  typedef enum logic [4:0] {
    // alu
    op_add, op_sub, op_slt, op_sltu, op_and, op_nor,
    op_or, op_xor, op_sll, op_srl, op_sra, op_lui,
    // divider
    op_div, op_divu, op_mod, op_modu,
    // loads
    op_ld_b, op_ld_bu, op_ld_h, op_ld_hu, op_ld_w,
    // stores
    op_st_b, op_st_h, op_st_w,
    // branches and jumps
    op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu, op_jirl, op_b
  } exe_op_t;

  // issued instruction
  typedef struct packed {
    exe_op_t op;
    word_t   src1;
    word_t   src2;
    word_t   imm;
    addr_t   pc;
    // taken prediction from fetch
    logic    pre_jump;
  } exe_req_t;

  // completed instruction
  typedef struct packed {
    word_t result;
    logic  need_jump;
    addr_t jump_target;
    logic  pre_fail;
    logic  excp_ale;
  } exe_rsp_t;

  // data cache request, word aligned address
  typedef struct packed {
    addr_t addr;
    logic  we;
    strb_t wstrb;
    word_t wdata;
  } dcache_req_t;

  typedef enum logic [1:0] {div_idle, div_run, div_finish} div_state_t;

  typedef enum logic [1:0] {lsu_idle, lsu_request, lsu_wait_data, lsu_fault} lsu_state_t;

endpackage
